// File: verilog/vxu_seq_pkg.sv
package vxu_seq_pkg;

  // Upper bound on the bank count
  localparam int MAX_SLOTS = 8;

  localparam int VLEN_W = 8;
  localparam int REG_W = 5;
  localparam int BREG_W = 7;
  localparam int IMM_W = 16;
  localparam int VIU_FN_W = 6;
  localparam int VAU0_FN_W = 4;

  // Remaining vector length, minus one
  typedef logic [VLEN_W-1:0] vlen_t;

  // Register as fired, then widened into the banked space
  typedef logic [REG_W-1:0] reg_t;
  typedef logic [BREG_W-1:0] breg_t;

  typedef logic [IMM_W-1:0] imm_t;

  typedef logic [VIU_FN_W-1:0] viu_fn_t;
  typedef logic [VAU0_FN_W-1:0] vau0_fn_t;

  // Queue positions in the stall vector
  localparam int QSTALL_VLDQ = 1;
  localparam int QSTALL_VSDQ = 0;

  typedef logic [1:0] qstall_t;

endpackage

// File: verilog/vxu_seq_ptr.sv
`timescale 1ns/100ps

module vxu_seq_ptr
#(
  parameter int n_slots = vxu_seq_pkg::MAX_SLOTS,
  localparam int ptr_w = $clog2(n_slots)
)
(
  input  logic             clk,
  input  logic             reset,
  input  logic [ptr_w:0]   bcnt,
  output logic [ptr_w-1:0] cur_slot,
  output logic [ptr_w-1:0] next_slot
);

  logic [ptr_w:0] succ;

  // Successor wraps at the run-time bank count, not at n_slots
  assign succ = {1'b0, cur_slot} + 1'b1;
  assign next_slot = (succ < bcnt) ? succ[ptr_w-1:0] : '0;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cur_slot <= '0;
    end
    else
    begin
      cur_slot <= next_slot;
    end
  end

  // Pointer stays inside the configured banks once bcnt has settled
  a_ptr_in_range: assert property (
    @(posedge clk) disable iff (reset)
    $stable(bcnt) |-> ({1'b0, cur_slot} < bcnt)
  );

endmodule

// File: verilog/vxu_seq_field.sv
`timescale 1ns/100ps

module vxu_seq_field
#(
  parameter int n_slots = vxu_seq_pkg::MAX_SLOTS,
  parameter type field_t = logic,
  localparam int ptr_w = $clog2(n_slots)
)
(
  input  logic             clk,
  input  logic             wr,
  input  logic [ptr_w-1:0] wr_slot,
  input  field_t           wr_data,
  input  logic [ptr_w-1:0] rd_slot,
  output field_t           rd_data
);

  field_t mem [n_slots];

  // Loaded at fire, held until the slot is reused
  always_ff @(posedge clk)
  begin
    if (wr)
    begin
      mem[wr_slot] <= wr_data;
    end
  end

  assign rd_data = mem[rd_slot];

endmodule

// File: verilog/vxu_seq_slots.sv
`timescale 1ns/100ps

module vxu_seq_slots
#(
  parameter int n_slots = vxu_seq_pkg::MAX_SLOTS,
  localparam int ptr_w = $clog2(n_slots)
)
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic [ptr_w:0]            bcnt,
  input  vxu_seq_pkg::vlen_t        vlen,
  input  vxu_seq_pkg::reg_t         stride,
  input  logic                      fire_viu,
  input  logic                      fire_vau0,
  input  logic                      fire_vlu,
  input  logic                      fire_vsu,
  input  logic                      fire_vs_zero,
  input  logic                      fire_vt_zero,
  input  vxu_seq_pkg::reg_t         fire_vs,
  input  vxu_seq_pkg::reg_t         fire_vt,
  input  vxu_seq_pkg::reg_t         fire_vd,
  input  logic [ptr_w-1:0]          next_slot,
  input  logic [ptr_w-1:0]          cur_slot,
  input  logic                      stall,
  output logic                      cur_val,
  output logic                      cur_last,
  output logic                      cur_viu,
  output logic                      cur_vau0,
  output logic                      cur_vldq,
  output logic                      cur_vsdq,
  output logic [ptr_w-1:0]          seq_cnt,
  output vxu_seq_pkg::vlen_t        seq_utidx,
  output vxu_seq_pkg::breg_t        seq_vs,
  output vxu_seq_pkg::breg_t        seq_vt,
  output vxu_seq_pkg::breg_t        seq_vd,
  output logic                      seq_vs_zero,
  output logic                      seq_vt_zero
);

  logic [n_slots-1:0] slot_val;
  logic [n_slots-1:0] slot_last;
  logic [n_slots-1:0] slot_viu;
  logic [n_slots-1:0] slot_vau0;
  logic [n_slots-1:0] slot_vldq;
  logic [n_slots-1:0] slot_vsdq;
  logic [n_slots-1:0] slot_vs_zero;
  logic [n_slots-1:0] slot_vt_zero;

  vxu_seq_pkg::vlen_t slot_rem [n_slots];
  vxu_seq_pkg::vlen_t slot_utidx [n_slots];
  vxu_seq_pkg::reg_t slot_stride [n_slots];
  vxu_seq_pkg::breg_t slot_vs [n_slots];
  vxu_seq_pkg::breg_t slot_vt [n_slots];
  vxu_seq_pkg::breg_t slot_vd [n_slots];

  logic fire_any;
  logic issue;
  logic [ptr_w:0] bcntm1;
  vxu_seq_pkg::vlen_t rem_next;
  vxu_seq_pkg::breg_t step;

  assign fire_any = fire_viu | fire_vau0 | fire_vlu | fire_vsu;
  assign issue = cur_val & ~stall;
  assign bcntm1 = bcnt - 1'b1;

  // Group size is the remainder, capped at one bank sweep
  assign seq_cnt = (slot_rem[cur_slot] < bcntm1) ? slot_rem[cur_slot][ptr_w-1:0]
                                                 : bcntm1[ptr_w-1:0];
  assign rem_next = slot_rem[cur_slot] - vxu_seq_pkg::vlen_t'(seq_cnt) - 1'b1;
  assign step = vxu_seq_pkg::breg_t'(slot_stride[cur_slot]);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      slot_val <= '0;
      slot_last <= '0;
      slot_viu <= '0;
      slot_vau0 <= '0;
      slot_vldq <= '0;
      slot_vsdq <= '0;
    end
    else
    begin
      if (issue)
      begin
        if (slot_last[cur_slot])
        begin
          slot_val[cur_slot] <= 1'b0;
        end
        else if (rem_next < bcnt)
        begin
          slot_last[cur_slot] <= 1'b1;
        end
      end
      if (fire_any)
      begin
        slot_val[next_slot] <= 1'b1;
        slot_last[next_slot] <= vlen < bcnt;
        slot_viu[next_slot] <= fire_viu;
        slot_vau0[next_slot] <= fire_vau0;
        slot_vldq[next_slot] <= fire_vlu;
        slot_vsdq[next_slot] <= fire_vsu;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      slot_rem[cur_slot] <= rem_next;
      slot_utidx[cur_slot] <= slot_utidx[cur_slot] + vxu_seq_pkg::vlen_t'(bcnt);
      slot_vs[cur_slot] <= slot_vs[cur_slot] + step;
      slot_vt[cur_slot] <= slot_vt[cur_slot] + step;
      slot_vd[cur_slot] <= slot_vd[cur_slot] + step;
    end
    if (fire_any)
    begin
      slot_rem[next_slot] <= vlen;
      slot_utidx[next_slot] <= '0;
      slot_stride[next_slot] <= stride;
      slot_vs[next_slot] <= vxu_seq_pkg::breg_t'(fire_vs);
      slot_vt[next_slot] <= vxu_seq_pkg::breg_t'(fire_vt);
      slot_vd[next_slot] <= vxu_seq_pkg::breg_t'(fire_vd);
      slot_vs_zero[next_slot] <= fire_vs_zero;
      slot_vt_zero[next_slot] <= fire_vt_zero;
    end
  end

  assign cur_val = slot_val[cur_slot];
  assign cur_last = slot_last[cur_slot];
  assign cur_viu = slot_viu[cur_slot];
  assign cur_vau0 = slot_vau0[cur_slot];
  assign cur_vldq = slot_vldq[cur_slot];
  assign cur_vsdq = slot_vsdq[cur_slot];

  assign seq_utidx = slot_utidx[cur_slot];
  assign seq_vs = slot_vs[cur_slot];
  assign seq_vt = slot_vt[cur_slot];
  assign seq_vd = slot_vd[cur_slot];
  assign seq_vs_zero = slot_vs_zero[cur_slot];
  assign seq_vt_zero = slot_vt_zero[cur_slot];

  a_one_fire: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0({fire_viu, fire_vau0, fire_vlu, fire_vsu})
  );

  // The slot the pointer reaches next must have drained
  a_fire_free_slot: assert property (
    @(posedge clk) disable iff (reset)
    fire_any |-> !slot_val[next_slot]
  );

endmodule

// File: verilog/vxu_seq_deps.sv
`timescale 1ns/100ps

module vxu_seq_deps
#(
  parameter int n_slots = vxu_seq_pkg::MAX_SLOTS,
  localparam int ptr_w = $clog2(n_slots)
)
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 fire_viu,
  input  logic                 fire_vau0,
  input  logic                 fire_vlu,
  input  logic                 fire_vsu,
  input  logic [ptr_w-1:0]     next_slot,
  input  logic [ptr_w-1:0]     cur_slot,
  input  logic                 cur_val,
  input  logic                 cur_vldq,
  input  logic                 cur_vsdq,
  input  logic                 vldq_qstall,
  input  logic                 vsdq_qstall,
  output logic                 stall,
  output vxu_seq_pkg::qstall_t seq_stall
);

  logic [n_slots-1:0] dep_vldq;
  logic [n_slots-1:0] dep_vsdq;
  logic vldq_stall_q;
  logic vsdq_stall_q;
  logic use_vldq;
  logic use_vsdq;

  assign use_vldq = cur_val & cur_vldq;
  assign use_vsdq = cur_val & cur_vsdq;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      dep_vldq <= '0;
      dep_vsdq <= '0;
    end
    else if (fire_viu | fire_vau0)
    begin
      dep_vldq[next_slot] <= 1'b1;
      dep_vsdq[next_slot] <= 1'b1;
    end
    else if (fire_vlu)
    begin
      // New load releases everyone waiting on the load queue
      dep_vldq <= '0;
      dep_vsdq[next_slot] <= 1'b1;
    end
    else if (fire_vsu)
    begin
      dep_vsdq <= '0;
      dep_vldq[next_slot] <= 1'b1;
    end
  end

  // Stall memory only samples when the visited slot owns the queue
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      vldq_stall_q <= 1'b0;
      vsdq_stall_q <= 1'b0;
    end
    else
    begin
      if (use_vldq)
      begin
        vldq_stall_q <= vldq_qstall;
      end
      if (use_vsdq)
      begin
        vsdq_stall_q <= vsdq_qstall;
      end
    end
  end

  assign stall = (dep_vldq[cur_slot] & vldq_stall_q)
               | (dep_vsdq[cur_slot] & vsdq_stall_q)
               | (use_vldq & vldq_qstall)
               | (use_vsdq & vsdq_qstall);

  assign seq_stall[vxu_seq_pkg::QSTALL_VLDQ] = vldq_stall_q;
  assign seq_stall[vxu_seq_pkg::QSTALL_VSDQ] = vsdq_stall_q;

endmodule

// File: verilog/vxu_seq.sv
`timescale 1ns/100ps

module vxu_seq
#(
  parameter int n_slots = vxu_seq_pkg::MAX_SLOTS,
  localparam int ptr_w = $clog2(n_slots)
)
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic [ptr_w:0]            bcnt,
  input  vxu_seq_pkg::vlen_t        vlen,
  input  vxu_seq_pkg::reg_t         stride,
  input  logic                      vldq_qstall,
  input  logic                      vsdq_qstall,
  input  logic                      fire_viu,
  input  logic                      fire_vau0,
  input  logic                      fire_vlu,
  input  logic                      fire_vsu,
  input  vxu_seq_pkg::viu_fn_t      fire_fn_viu,
  input  vxu_seq_pkg::vau0_fn_t     fire_fn_vau0,
  input  logic                      fire_vs_zero,
  input  logic                      fire_vt_zero,
  input  vxu_seq_pkg::reg_t         fire_vs,
  input  vxu_seq_pkg::reg_t         fire_vt,
  input  vxu_seq_pkg::reg_t         fire_vd,
  input  vxu_seq_pkg::imm_t         fire_imm,
  output vxu_seq_pkg::qstall_t      seq_stall,
  output logic                      seq_last,
  output logic                      seq_viu,
  output logic                      seq_vau0,
  output logic                      seq_vldq,
  output logic                      seq_vsdq,
  output vxu_seq_pkg::viu_fn_t      seq_fn_viu,
  output vxu_seq_pkg::vau0_fn_t     seq_fn_vau0,
  output logic [ptr_w-1:0]          seq_cnt,
  output vxu_seq_pkg::vlen_t        seq_utidx,
  output logic                      seq_vs_zero,
  output logic                      seq_vt_zero,
  output vxu_seq_pkg::breg_t        seq_vs,
  output vxu_seq_pkg::breg_t        seq_vt,
  output vxu_seq_pkg::breg_t        seq_vd,
  output vxu_seq_pkg::imm_t         seq_imm
);

  logic [ptr_w-1:0] cur_slot;
  logic [ptr_w-1:0] next_slot;
  logic cur_val;
  logic cur_last;
  logic cur_viu;
  logic cur_vau0;
  logic cur_vldq;
  logic cur_vsdq;
  logic stall;
  logic issue;

  vxu_seq_ptr #(.n_slots(n_slots)) u_ptr (
    .clk       (clk),
    .reset     (reset),
    .bcnt      (bcnt),
    .cur_slot  (cur_slot),
    .next_slot (next_slot)
  );

  vxu_seq_slots #(.n_slots(n_slots)) u_slots (
    .clk          (clk),
    .reset        (reset),
    .bcnt         (bcnt),
    .vlen         (vlen),
    .stride       (stride),
    .fire_viu     (fire_viu),
    .fire_vau0    (fire_vau0),
    .fire_vlu     (fire_vlu),
    .fire_vsu     (fire_vsu),
    .fire_vs_zero (fire_vs_zero),
    .fire_vt_zero (fire_vt_zero),
    .fire_vs      (fire_vs),
    .fire_vt      (fire_vt),
    .fire_vd      (fire_vd),
    .next_slot    (next_slot),
    .cur_slot     (cur_slot),
    .stall        (stall),
    .cur_val      (cur_val),
    .cur_last     (cur_last),
    .cur_viu      (cur_viu),
    .cur_vau0     (cur_vau0),
    .cur_vldq     (cur_vldq),
    .cur_vsdq     (cur_vsdq),
    .seq_cnt      (seq_cnt),
    .seq_utidx    (seq_utidx),
    .seq_vs       (seq_vs),
    .seq_vt       (seq_vt),
    .seq_vd       (seq_vd),
    .seq_vs_zero  (seq_vs_zero),
    .seq_vt_zero  (seq_vt_zero)
  );

  vxu_seq_deps #(.n_slots(n_slots)) u_deps (
    .clk         (clk),
    .reset       (reset),
    .fire_viu    (fire_viu),
    .fire_vau0   (fire_vau0),
    .fire_vlu    (fire_vlu),
    .fire_vsu    (fire_vsu),
    .next_slot   (next_slot),
    .cur_slot    (cur_slot),
    .cur_val     (cur_val),
    .cur_vldq    (cur_vldq),
    .cur_vsdq    (cur_vsdq),
    .vldq_qstall (vldq_qstall),
    .vsdq_qstall (vsdq_qstall),
    .stall       (stall),
    .seq_stall   (seq_stall)
  );

  vxu_seq_field #(.n_slots(n_slots), .field_t(vxu_seq_pkg::viu_fn_t)) u_fn_viu (
    .clk     (clk),
    .wr      (fire_viu),
    .wr_slot (next_slot),
    .wr_data (fire_fn_viu),
    .rd_slot (cur_slot),
    .rd_data (seq_fn_viu)
  );

  vxu_seq_field #(.n_slots(n_slots), .field_t(vxu_seq_pkg::vau0_fn_t)) u_fn_vau0 (
    .clk     (clk),
    .wr      (fire_vau0),
    .wr_slot (next_slot),
    .wr_data (fire_fn_vau0),
    .rd_slot (cur_slot),
    .rd_data (seq_fn_vau0)
  );

  // Only the integer unit carries an immediate
  vxu_seq_field #(.n_slots(n_slots), .field_t(vxu_seq_pkg::imm_t)) u_imm (
    .clk     (clk),
    .wr      (fire_viu),
    .wr_slot (next_slot),
    .wr_data (fire_imm),
    .rd_slot (cur_slot),
    .rd_data (seq_imm)
  );

  assign issue = cur_val & ~stall;

  assign seq_last = issue & cur_last;
  assign seq_viu = issue & cur_viu;
  assign seq_vau0 = issue & cur_vau0;
  assign seq_vldq = issue & cur_vldq;
  assign seq_vsdq = issue & cur_vsdq;

endmodule

// File: verif/vxu_seq_tb.sv
`timescale 1ns/100ps

module vxu_seq_tb;

  localparam int n_slots = vxu_seq_pkg::MAX_SLOTS;
  localparam int ptr_w = $clog2(n_slots);
  localparam int timeout_cycles = 2000;

  logic clk;
  logic reset;
  logic [ptr_w:0] bcnt;
  vxu_seq_pkg::vlen_t vlen;
  vxu_seq_pkg::reg_t stride;
  logic vldq_qstall;
  logic vsdq_qstall;
  logic fire_viu;
  logic fire_vau0;
  logic fire_vlu;
  logic fire_vsu;
  vxu_seq_pkg::viu_fn_t fire_fn_viu;
  vxu_seq_pkg::vau0_fn_t fire_fn_vau0;
  logic fire_vs_zero;
  logic fire_vt_zero;
  vxu_seq_pkg::reg_t fire_vs;
  vxu_seq_pkg::reg_t fire_vt;
  vxu_seq_pkg::reg_t fire_vd;
  vxu_seq_pkg::imm_t fire_imm;
  vxu_seq_pkg::qstall_t seq_stall;
  logic seq_last;
  logic seq_viu;
  logic seq_vau0;
  logic seq_vldq;
  logic seq_vsdq;
  vxu_seq_pkg::viu_fn_t seq_fn_viu;
  vxu_seq_pkg::vau0_fn_t seq_fn_vau0;
  logic [ptr_w-1:0] seq_cnt;
  vxu_seq_pkg::vlen_t seq_utidx;
  logic seq_vs_zero;
  logic seq_vt_zero;
  vxu_seq_pkg::breg_t seq_vs;
  vxu_seq_pkg::breg_t seq_vt;
  vxu_seq_pkg::breg_t seq_vd;
  vxu_seq_pkg::imm_t seq_imm;

  // Current data file line
  logic [8*24-1:0] name;
  logic [8*8-1:0] op;
  int t_bcnt, t_vlen, t_stride;
  int t_vs, t_vt, t_vd;
  int t_fn, t_imm, t_hold, t_groups;

  // Per operation tracking, index 0 viu, 1 vau0, 2 vlu, 3 vsu
  logic [3:0] active;
  logic [3:0] done;
  logic [1:0] stall_seen;
  int groups_seen [4];
  int fire_cyc [4];
  int first_cyc [4];
  int prev_cyc [4];

  vxu_seq #(.n_slots(n_slots)) u_vxu_seq (.*);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #10 clk = ~clk;
    end
  end

  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_value(input string what, input int expected, input int actual);
    assert (actual == expected)
    else
    begin
      $display("** Error in %0s: %0s expected %0d, actual %0d", name, what, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic require(input logic ok, input string msg);
    assert (ok)
    else
    begin
      $display("Test %0s failed: %0s", name, msg);
      stop_on_error();
    end
  endtask

  task automatic fire_op(input int k, input int cyc);
    fire_viu = (k == 0);
    fire_vau0 = (k == 1);
    fire_vlu = (k == 2);
    fire_vsu = (k == 3);
    if (k >= 0)
    begin
      active[k] = 1'b1;
      fire_cyc[k] = cyc;
    end
  endtask

  task automatic verify_group(input int k, input int cyc);
    int g;
    int rem;
    int gap;
    g = groups_seen[k];
    require(active[k] && !done[k], "issue pulse from an operation that is not in flight");
    rem = t_vlen - g * t_bcnt;
    compare_value("seq_cnt", (rem < t_bcnt - 1) ? rem : t_bcnt - 1, seq_cnt);
    compare_value("seq_last", (g == t_vlen / t_bcnt) ? 1 : 0, seq_last);
    compare_value("seq_utidx", (g * t_bcnt) % 256, seq_utidx);
    compare_value("seq_vs", (t_vs + g * t_stride) % 128, seq_vs);
    compare_value("seq_vt", (t_vt + g * t_stride) % 128, seq_vt);
    compare_value("seq_vd", (t_vd + g * t_stride) % 128, seq_vd);
    compare_value("seq_vs_zero", (t_vs == 0) ? 1 : 0, seq_vs_zero);
    compare_value("seq_vt_zero", (t_vt == 0) ? 1 : 0, seq_vt_zero);
    if (k == 0)
    begin
      compare_value("seq_fn_viu", t_fn, seq_fn_viu);
      compare_value("seq_imm", t_imm, seq_imm);
    end
    else if (k == 1)
    begin
      compare_value("seq_fn_vau0", t_fn, seq_fn_vau0);
    end
    gap = (g == 0) ? cyc - fire_cyc[k] - 1 : cyc - prev_cyc[k] - t_bcnt;
    // A stalled visit pushes the issue back by whole bank sweeps
    if (t_hold == 0)
    begin
      compare_value("issue gap", 0, gap);
    end
    else
    begin
      compare_value("issue gap modulo bcnt", 0, gap % t_bcnt);
    end
    if (g == 0)
    begin
      first_cyc[k] = cyc;
    end
    prev_cyc[k] = cyc;
    groups_seen[k] = g + 1;
    done[k] = seq_last;
  endtask

  task automatic sample_cycle(input int cyc);
    logic [3:0] flags;
    int k;
    flags = {seq_vsdq, seq_vldq, seq_vau0, seq_viu};
    require(!(flags == 4'b0 && seq_last), "seq_last high without an issue pulse");
    require(!(vldq_qstall && seq_vldq), "load issued while vldq was stalled");
    require(!(vsdq_qstall && seq_vsdq), "store issued while vsdq was stalled");
    require(!(seq_stall[1] && seq_viu), "viu issued while the vldq stall memory was set");
    stall_seen = stall_seen | seq_stall;
    for (k = 0; k < 4; k++)
    begin
      if (flags[k])
      begin
        verify_group(k, cyc);
      end
    end
  endtask

  task automatic run_test();
    int k;
    int i;
    int cyc;
    require(op == "viu" || op == "vau0" || op == "vlu" || op == "vsu" || op == "dep",
            "unknown operation in the data file");
    k = (op == "viu") ? 0 : (op == "vau0") ? 1 : (op == "vsu") ? 3 : 2;
    active = '0;
    done = '0;
    stall_seen = '0;
    for (i = 0; i < 4; i++)
    begin
      groups_seen[i] = 0;
    end
    // One idle sweep so earlier slots have drained
    repeat (n_slots) @(negedge clk);
    bcnt = t_bcnt;
    vlen = t_vlen;
    stride = t_stride;
    fire_vs = t_vs;
    fire_vt = t_vt;
    fire_vd = t_vd;
    fire_vs_zero = (t_vs == 0);
    fire_vt_zero = (t_vt == 0);
    fire_fn_viu = t_fn;
    fire_fn_vau0 = t_fn;
    fire_imm = t_imm;
    cyc = 0;
    fire_op(k, cyc);
    vldq_qstall = (t_hold > 0) && (k == 2);
    vsdq_qstall = (t_hold > 0) && (k == 3);
    while (done != active)
    begin
      @(negedge clk);
      cyc++;
      require(cyc <= timeout_cycles, "issue did not appear before the timeout");
      fire_op(-1, cyc);
      if (op == "dep" && cyc == 1)
      begin
        fire_op(0, cyc);
      end
      if (cyc >= t_hold)
      begin
        vldq_qstall = 1'b0;
        vsdq_qstall = 1'b0;
      end
      // Sample just before the edge that commits this cycle
      @(posedge clk);
      sample_cycle(cyc);
    end
    for (i = 0; i < 4; i++)
    begin
      if (active[i])
      begin
        compare_value("group count", t_groups, groups_seen[i]);
      end
    end
    if (t_hold > 0)
    begin
      compare_value("seq_stall rise", 1, (k == 3) ? stall_seen[0] : stall_seen[1]);
    end
    if (op == "dep")
    begin
      require(first_cyc[0] > first_cyc[2], "viu issued before the stalled load resumed");
    end
  endtask

  initial
  begin
    int fd;
    int code;
    int ntests;
    logic [8*160-1:0] line;
    reset = 1'b1;
    bcnt = 4;
    vlen = '0;
    stride = '0;
    vldq_qstall = 1'b0;
    vsdq_qstall = 1'b0;
    fire_viu = 1'b0;
    fire_vau0 = 1'b0;
    fire_vlu = 1'b0;
    fire_vsu = 1'b0;
    fire_fn_viu = '0;
    fire_fn_vau0 = '0;
    fire_vs_zero = 1'b0;
    fire_vt_zero = 1'b0;
    fire_vs = '0;
    fire_vt = '0;
    fire_vd = '0;
    fire_imm = '0;
    name = "reset_idle";
    ntests = 0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    repeat (20)
    begin
      @(negedge clk);
      require({seq_viu, seq_vau0, seq_vldq, seq_vsdq, seq_last} == 5'b0 && seq_stall == 2'b0,
              "issue activity right after reset");
    end
    fd = $fopen("verif/vxu_seq_tests.dat", "r");
    require(fd != 0, "could not open verif/vxu_seq_tests.dat");
    while (!$feof(fd))
    begin
      line = '0;
      code = $fgets(line, fd);
      // Comment and blank lines do not parse into all twelve fields
      if (code > 0 && $sscanf(line, "%s %s %d %d %d %d %d %d %d %d %d %d", name, op, t_bcnt,
                              t_vlen, t_stride, t_vs, t_vt, t_vd, t_fn, t_imm, t_hold,
                              t_groups) == 12)
      begin
        run_test();
        ntests++;
      end
    end
    $fclose(fd);
    if (ntests > 0)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
    begin
      $display("No test lines were read from the data file");
      stop_on_error();
    end
  end

endmodule

// File: verif/vxu_seq_tests.dat
# name op bcnt vlen stride vs vt vd fn imm stall_cycles groups
# op is viu, vau0, vlu, vsu, or dep for a vlu with a viu fired one cycle behind it
viu_bcnt4_vlen9     viu   4   9   1   3   4   5  37  4660   0   3
vau0_stride31_wrap  vau0  4  40  31  30   7  31   9     0   0  11
vsu_stride17_wrap   vsu   8  63  17  29   1  20   0     0   0   8
vau0_stride13       vau0  2  21  13   0  31  15   5     0   0  11
vlu_hold12          vlu   4  15   3   2   6  10   0     0  12   4
vlu_hold30          vlu   8  20   5   1   1   1   0     0  30   3
vsu_hold9           vsu   4   7   5   3   3   3   0     0   9   2
dep_vlu_viu         dep   4  11   1   8   9  10  21 43981  14   3
viu_bcnt1           viu   1   5   7   1   2   3  63 65535   0   6
vlu_bcnt1_hold4     vlu   1   3   1   0   0   0   0     0   4   4
vsu_bcnt2           vsu   2   6   9  11  12  13   0     0   0   4
vau0_bcnt8_vlen0    vau0  8   0  25   4   5   6  15     0   0   1
viu_bcnt8_vlen255   viu   8 255   3  31   0  16   1     1   0  32
vau0_bcnt2_vlen1    vau0  2   1  19  17  18  19   3     0   0   1
viu_bcnt4_vlen3     viu   4   3  11   5   0   9  12   100   0   1

// File: sources.f
verilog/vxu_seq_pkg.sv
verilog/vxu_seq_ptr.sv
verilog/vxu_seq_field.sv
verilog/vxu_seq_slots.sv
verilog/vxu_seq_deps.sv
verilog/vxu_seq.sv
verif/vxu_seq_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the vxu_seq testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module vxu_seq_tb -f sources.f

./obj_dir/Vvxu_seq_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
